//--- common/wb_soc_pkg.sv
package wb_soc_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  // Byte address and data word
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // One select bit per byte lane
  localparam int SEL_W  = DATA_W / 8;

  //////////////////////////////////////////////////
  // Memory map
  //////////////////////////////////////////////////

  // Four banks of 256 words, 4 KB in all
  localparam int NUM_BANKS   = 4;
  localparam int BANK_WORDS  = 256;
  localparam int BANK_AW     = 8;
  // Every address bit from here upward is zero in the window
  localparam int MAP_TOP_BIT = 12;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0] wb_addr_t;
  typedef logic [DATA_W-1:0] wb_data_t;
  typedef logic [SEL_W-1:0]  wb_sel_t;

  // Bank number, address bits 11 to 10
  typedef logic [$clog2(NUM_BANKS)-1:0] bank_idx_t;
  // Word inside a bank, address bits 9 to 2
  typedef logic [BANK_AW-1:0] bank_word_t;
  // One bit per bank for strobes and acks
  typedef logic [NUM_BANKS-1:0] bank_vec_t;

  //////////////////////////////////////////////////
  // Arbiter FSM
  //////////////////////////////////////////////////

  // Who owns the shared bus
  typedef enum logic [1:0] {
    ARB_IDLE = 2'd0,
    ARB_CPU  = 2'd1,
    ARB_DBG  = 2'd2
  } arb_state_e;

endpackage

//--- files.f
common/wb_soc_pkg.sv
interconnect/wb_master_arbiter.sv
interconnect/wb_slave_decoder.sv
memory/wb_ram_bank.sv
interconnect/wb_response_mux.sv
logic/pu_wb_subsystem.sv
tests/tb_pu_wb_subsystem.sv

//--- interconnect/wb_master_arbiter.sv
`timescale 1ns/10ps

module wb_master_arbiter (
  input  logic                  wb_clk_i,
  input  logic                  reset_i,

  // CPU data master
  input  wb_soc_pkg::wb_addr_t  cpu_adr_i,
  input  wb_soc_pkg::wb_data_t  cpu_dat_i,
  input  wb_soc_pkg::wb_sel_t   cpu_sel_i,
  input  logic                  cpu_we_i,
  input  logic                  cpu_cyc_i,
  input  logic                  cpu_stb_i,
  output wb_soc_pkg::wb_data_t  cpu_dat_o,
  output logic                  cpu_ack_o,
  output logic                  cpu_err_o,

  // Debug master
  input  wb_soc_pkg::wb_addr_t  dbg_adr_i,
  input  wb_soc_pkg::wb_data_t  dbg_dat_i,
  input  wb_soc_pkg::wb_sel_t   dbg_sel_i,
  input  logic                  dbg_we_i,
  input  logic                  dbg_cyc_i,
  input  logic                  dbg_stb_i,
  output wb_soc_pkg::wb_data_t  dbg_dat_o,
  output logic                  dbg_ack_o,
  output logic                  dbg_err_o,

  // Shared bus towards the decoder
  output wb_soc_pkg::wb_addr_t  bus_adr_o,
  output wb_soc_pkg::wb_data_t  bus_dat_o,
  output wb_soc_pkg::wb_sel_t   bus_sel_o,
  output logic                  bus_we_o,
  output logic                  bus_stb_o,
  input  wb_soc_pkg::wb_data_t  bus_dat_i,
  input  logic                  bus_ack_i,
  input  logic                  bus_err_i
);

  wb_soc_pkg::arb_state_e state_q;
  wb_soc_pkg::arb_state_e state_d;

  // Set when the debug master had the last grant
  logic last_dbg_q;

  logic cpu_req;
  logic dbg_req;
  logic cpu_gnt;
  logic dbg_gnt;

  // A request is a full cyc plus stb
  assign cpu_req = cpu_cyc_i & cpu_stb_i;
  assign dbg_req = dbg_cyc_i & dbg_stb_i;

  assign cpu_gnt = (state_q == wb_soc_pkg::ARB_CPU);
  assign dbg_gnt = (state_q == wb_soc_pkg::ARB_DBG);

  //////////////////////////////////////////////////
  // Grant FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      wb_soc_pkg::ARB_IDLE: begin
        // On a tie the master not granted last wins
        if (cpu_req && (!dbg_req || last_dbg_q)) begin
          state_d = wb_soc_pkg::ARB_CPU;
        end else if (dbg_req) begin
          state_d = wb_soc_pkg::ARB_DBG;
        end
      end
      // Hold until the owner drops cyc
      wb_soc_pkg::ARB_CPU: begin
        if (!cpu_cyc_i) begin
          state_d = wb_soc_pkg::ARB_IDLE;
        end
      end
      wb_soc_pkg::ARB_DBG: begin
        if (!dbg_cyc_i) begin
          state_d = wb_soc_pkg::ARB_IDLE;
        end
      end
      default: begin
        state_d = wb_soc_pkg::ARB_IDLE;
      end
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      state_q    <= wb_soc_pkg::ARB_IDLE;
      // Looks like debug went last, so CPU wins the first tie
      last_dbg_q <= 1'b1;
    end else begin
      state_q <= state_d;
      // Remember the winner of each new grant
      if (state_q == wb_soc_pkg::ARB_IDLE && state_d != wb_soc_pkg::ARB_IDLE) begin
        last_dbg_q <= (state_d == wb_soc_pkg::ARB_DBG);
      end
    end
  end

  //////////////////////////////////////////////////
  // Request and response routing
  //////////////////////////////////////////////////

  // Granted master drives the bus, idle bus is quiet
  always_comb begin
    bus_adr_o = '0;
    bus_dat_o = '0;
    bus_sel_o = '0;
    bus_we_o  = 1'b0;
    bus_stb_o = 1'b0;
    if (cpu_gnt) begin
      bus_adr_o = cpu_adr_i;
      bus_dat_o = cpu_dat_i;
      bus_sel_o = cpu_sel_i;
      bus_we_o  = cpu_we_i;
      bus_stb_o = cpu_req;
    end else if (dbg_gnt) begin
      bus_adr_o = dbg_adr_i;
      bus_dat_o = dbg_dat_i;
      bus_sel_o = dbg_sel_i;
      bus_we_o  = dbg_we_i;
      bus_stb_o = dbg_req;
    end
  end

  // Response reaches the owner only
  assign cpu_dat_o = cpu_gnt ? bus_dat_i : '0;
  assign cpu_ack_o = cpu_gnt & bus_ack_i;
  assign cpu_err_o = cpu_gnt & bus_err_i;

  assign dbg_dat_o = dbg_gnt ? bus_dat_i : '0;
  assign dbg_ack_o = dbg_gnt & bus_ack_i;
  assign dbg_err_o = dbg_gnt & bus_err_i;

endmodule

//--- interconnect/wb_response_mux.sv
`timescale 1ns/10ps

module wb_response_mux (
  // Bank responses
  input  wb_soc_pkg::bank_vec_t                           bank_ack_i,
  input  wb_soc_pkg::wb_data_t [wb_soc_pkg::NUM_BANKS-1:0] bank_dat_i,

  // Decoder error
  input  logic                                            dec_err_i,

  // Merged response to the arbiter
  output logic                                            bus_ack_o,
  output logic                                            bus_err_o,
  output wb_soc_pkg::wb_data_t                            bus_dat_o
);

  wb_soc_pkg::wb_data_t rd_mux;

  // Any bank ack ends the cycle
  assign bus_ack_o = |bank_ack_i;

  // Unmapped cycles never strobe a bank, so err and ack stay exclusive
  assign bus_err_o = dec_err_i;

  //////////////////////////////////////////////////
  // Read data select
  //////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;
    // AND-OR over one-hot acks, zero when idle
    for (int i = 0; i < wb_soc_pkg::NUM_BANKS; i++) begin
      rd_mux = rd_mux | (bank_dat_i[i] & {wb_soc_pkg::DATA_W{bank_ack_i[i]}});
    end
  end

  assign bus_dat_o = rd_mux;

endmodule

//--- interconnect/wb_slave_decoder.sv
`timescale 1ns/10ps

module wb_slave_decoder (
  input  logic                   wb_clk_i,
  input  logic                   reset_i,

  // Shared bus from the arbiter
  input  wb_soc_pkg::wb_addr_t   bus_adr_i,
  input  wb_soc_pkg::wb_data_t   bus_dat_i,
  input  wb_soc_pkg::wb_sel_t    bus_sel_i,
  input  logic                   bus_we_i,
  input  logic                   bus_stb_i,

  // Fan-out to the RAM banks
  output wb_soc_pkg::bank_vec_t  bank_stb_o,
  output wb_soc_pkg::bank_word_t bank_word_o,
  output wb_soc_pkg::wb_data_t   bank_dat_o,
  output wb_soc_pkg::wb_sel_t    bank_sel_o,
  output logic                   bank_we_o,

  // Unmapped cycle
  output logic                   dec_err_o
);

  logic                  mapped;
  wb_soc_pkg::bank_idx_t bank_idx;
  logic                  err_q;

  // Inside the 4 KB window all upper bits are zero
  assign mapped = ~|bus_adr_i[wb_soc_pkg::ADDR_W-1:wb_soc_pkg::MAP_TOP_BIT];

  // Bank number sits right below the window limit
  assign bank_idx =
    bus_adr_i[wb_soc_pkg::MAP_TOP_BIT-1 -: $bits(wb_soc_pkg::bank_idx_t)];

  // Word index above the byte offset
  assign bank_word_o = bus_adr_i[wb_soc_pkg::BANK_AW+1:2];

  //////////////////////////////////////////////////
  // Bank strobes
  //////////////////////////////////////////////////

  always_comb begin
    bank_stb_o = '0;
    // One-hot, and only for mapped cycles
    if (bus_stb_i && mapped) begin
      bank_stb_o[bank_idx] = 1'b1;
    end
  end

  // Write side is common to every bank
  assign bank_dat_o = bus_dat_i;
  assign bank_sel_o = bus_sel_i;
  assign bank_we_o  = bus_we_i;

  //////////////////////////////////////////////////
  // Error response
  //////////////////////////////////////////////////

  // One pulse a cycle after an unmapped strobe
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else begin
      // Pulse clears itself while stb is still held
      err_q <= bus_stb_i & ~mapped & ~err_q;
    end
  end

  assign dec_err_o = err_q;

endmodule

//--- logic/pu_wb_subsystem.sv
`timescale 1ns/10ps

module pu_wb_subsystem (
  input  logic                 wb_clk_i,
  input  logic                 reset_i,

  // CPU data port
  input  wb_soc_pkg::wb_addr_t cpu_adr_i,
  input  wb_soc_pkg::wb_data_t cpu_dat_i,
  input  wb_soc_pkg::wb_sel_t  cpu_sel_i,
  input  logic                 cpu_we_i,
  input  logic                 cpu_cyc_i,
  input  logic                 cpu_stb_i,
  output wb_soc_pkg::wb_data_t cpu_dat_o,
  output logic                 cpu_ack_o,
  output logic                 cpu_err_o,

  // Debug port
  input  wb_soc_pkg::wb_addr_t dbg_adr_i,
  input  wb_soc_pkg::wb_data_t dbg_dat_i,
  input  wb_soc_pkg::wb_sel_t  dbg_sel_i,
  input  logic                 dbg_we_i,
  input  logic                 dbg_cyc_i,
  input  logic                 dbg_stb_i,
  output wb_soc_pkg::wb_data_t dbg_dat_o,
  output logic                 dbg_ack_o,
  output logic                 dbg_err_o
);

  // Shared bus after arbitration
  wb_soc_pkg::wb_addr_t bus_adr;
  wb_soc_pkg::wb_data_t bus_dat_w;
  wb_soc_pkg::wb_sel_t  bus_sel;
  logic                 bus_we;
  logic                 bus_stb;
  wb_soc_pkg::wb_data_t bus_dat_r;
  logic                 bus_ack;
  logic                 bus_err;

  // Decoder to banks
  wb_soc_pkg::bank_vec_t  bank_stb;
  wb_soc_pkg::bank_word_t bank_word;
  wb_soc_pkg::wb_data_t   bank_dat_w;
  wb_soc_pkg::wb_sel_t    bank_sel;
  logic                   bank_we;
  logic                   dec_err;

  // Banks to response mux
  wb_soc_pkg::bank_vec_t                           bank_ack;
  wb_soc_pkg::wb_data_t [wb_soc_pkg::NUM_BANKS-1:0] bank_dat_r;

  //////////////////////////////////////////////////
  // Master arbitration
  //////////////////////////////////////////////////

  wb_master_arbiter i_arbiter (
    .wb_clk_i  (wb_clk_i),
    .reset_i   (reset_i),
    .cpu_adr_i (cpu_adr_i),
    .cpu_dat_i (cpu_dat_i),
    .cpu_sel_i (cpu_sel_i),
    .cpu_we_i  (cpu_we_i),
    .cpu_cyc_i (cpu_cyc_i),
    .cpu_stb_i (cpu_stb_i),
    .cpu_dat_o (cpu_dat_o),
    .cpu_ack_o (cpu_ack_o),
    .cpu_err_o (cpu_err_o),
    .dbg_adr_i (dbg_adr_i),
    .dbg_dat_i (dbg_dat_i),
    .dbg_sel_i (dbg_sel_i),
    .dbg_we_i  (dbg_we_i),
    .dbg_cyc_i (dbg_cyc_i),
    .dbg_stb_i (dbg_stb_i),
    .dbg_dat_o (dbg_dat_o),
    .dbg_ack_o (dbg_ack_o),
    .dbg_err_o (dbg_err_o),
    .bus_adr_o (bus_adr),
    .bus_dat_o (bus_dat_w),
    .bus_sel_o (bus_sel),
    .bus_we_o  (bus_we),
    .bus_stb_o (bus_stb),
    .bus_dat_i (bus_dat_r),
    .bus_ack_i (bus_ack),
    .bus_err_i (bus_err)
  );

  // Address decode and unmapped error
  wb_slave_decoder i_decoder (
    .wb_clk_i    (wb_clk_i),
    .reset_i     (reset_i),
    .bus_adr_i   (bus_adr),
    .bus_dat_i   (bus_dat_w),
    .bus_sel_i   (bus_sel),
    .bus_we_i    (bus_we),
    .bus_stb_i   (bus_stb),
    .bank_stb_o  (bank_stb),
    .bank_word_o (bank_word),
    .bank_dat_o  (bank_dat_w),
    .bank_sel_o  (bank_sel),
    .bank_we_o   (bank_we),
    .dec_err_o   (dec_err)
  );

  //////////////////////////////////////////////////
  // RAM banks
  //////////////////////////////////////////////////

  for (genvar g = 0; g < wb_soc_pkg::NUM_BANKS; g++) begin : g_bank
    wb_ram_bank i_bank (
      .wb_clk_i (wb_clk_i),
      .reset_i  (reset_i),
      .stb_i    (bank_stb[g]),
      .we_i     (bank_we),
      .sel_i    (bank_sel),
      .word_i   (bank_word),
      .dat_i    (bank_dat_w),
      .dat_o    (bank_dat_r[g]),
      .ack_o    (bank_ack[g])
    );
  end

  // Merge bank and decoder responses
  wb_response_mux i_resp_mux (
    .bank_ack_i (bank_ack),
    .bank_dat_i (bank_dat_r),
    .dec_err_i  (dec_err),
    .bus_ack_o  (bus_ack),
    .bus_err_o  (bus_err),
    .bus_dat_o  (bus_dat_r)
  );

endmodule

//--- memory/wb_ram_bank.sv
`timescale 1ns/10ps

module wb_ram_bank (
  input  logic                   wb_clk_i,
  input  logic                   reset_i,

  // Request from the decoder
  input  logic                   stb_i,
  input  logic                   we_i,
  input  wb_soc_pkg::wb_sel_t    sel_i,
  input  wb_soc_pkg::bank_word_t word_i,
  input  wb_soc_pkg::wb_data_t   dat_i,

  // Response to the mux
  output wb_soc_pkg::wb_data_t   dat_o,
  output logic                   ack_o
);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // Single-port word array, contents survive reset
  wb_soc_pkg::wb_data_t mem [wb_soc_pkg::BANK_WORDS];

  wb_soc_pkg::wb_data_t rd_q;
  logic                 ack_q;
  logic                 access;

  // Act on the first cycle of a strobe only
  assign access = stb_i & ~ack_q;

  // Byte-lane writes
  always_ff @(posedge wb_clk_i) begin
    if (access && we_i) begin
      for (int b = 0; b < wb_soc_pkg::SEL_W; b++) begin
        // Untouched lanes keep their old byte
        if (sel_i[b]) begin
          mem[word_i][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end
    end
  end

  // Read word is captured together with the ack
  always_ff @(posedge wb_clk_i) begin
    if (access) begin
      rd_q <= mem[word_i];
    end
  end

  //////////////////////////////////////////////////
  // Acknowledge
  //////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      // Single pulse per strobe
      ack_q <= access;
    end
  end

  assign ack_o = ack_q;
  assign dat_o = rd_q;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the Wishbone subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_pu_wb_subsystem \
  -f files.f -o tb_sim || exit 1

out=$(./obj_dir/tb_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Simulation passed" && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tests/tb_pu_wb_subsystem.sv
`timescale 1ns/10ps

module tb_pu_wb_subsystem;

  localparam int          TIMEOUT    = 200;
  localparam int          NUM_RANDOM = 300;
  localparam int          NUM_TIES   = 16;
  localparam logic [31:0] SEED       = 32'hfee1_0343;

  logic                 wb_clk_i;
  logic                 reset_i;
  wb_soc_pkg::wb_addr_t cpu_adr_i;
  wb_soc_pkg::wb_data_t cpu_dat_i;
  wb_soc_pkg::wb_sel_t  cpu_sel_i;
  logic                 cpu_we_i;
  logic                 cpu_cyc_i;
  logic                 cpu_stb_i;
  wb_soc_pkg::wb_data_t cpu_dat_o;
  logic                 cpu_ack_o;
  logic                 cpu_err_o;
  wb_soc_pkg::wb_addr_t dbg_adr_i;
  wb_soc_pkg::wb_data_t dbg_dat_i;
  wb_soc_pkg::wb_sel_t  dbg_sel_i;
  logic                 dbg_we_i;
  logic                 dbg_cyc_i;
  logic                 dbg_stb_i;
  wb_soc_pkg::wb_data_t dbg_dat_o;
  logic                 dbg_ack_o;
  logic                 dbg_err_o;

  // Reference copy of the whole 4 KB window
  wb_soc_pkg::wb_data_t ref_mem [1024];
  wb_soc_pkg::wb_data_t cpu_exp;
  wb_soc_pkg::wb_data_t dbg_exp;

  // Round-robin history as seen from completions
  logic last_dbg;
  logic tie_open;
  logic tie_done;

  pu_wb_subsystem i_dut (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #4 wb_clk_i = ~wb_clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic stop_on_failure(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  function automatic wb_soc_pkg::wb_addr_t mapped_addr(input int word);
    mapped_addr = {20'h0, 10'(word), 2'b00};
  endfunction

  // At least one bit at or above bit 12
  function automatic wb_soc_pkg::wb_addr_t unmapped_addr();
    wb_soc_pkg::wb_addr_t adr;
    adr = $urandom() & 32'hffff_fffc;
    adr[31:12] = adr[31:12] | (20'h1 << $urandom_range(19, 0));
    unmapped_addr = adr;
  endfunction

  // One classic cycle, held until ack or err
  task automatic transfer(input bit use_dbg, input wb_soc_pkg::wb_addr_t adr,
                          input wb_soc_pkg::wb_data_t dat, input wb_soc_pkg::wb_sel_t sel,
                          input bit we);
    int waited;
    bit done;
    waited = 0;
    done   = 1'b0;
    @(negedge wb_clk_i);
    if (use_dbg) begin
      dbg_adr_i = adr;
      dbg_dat_i = dat;
      dbg_sel_i = sel;
      dbg_we_i  = we;
      dbg_cyc_i = 1'b1;
      dbg_stb_i = 1'b1;
    end else begin
      cpu_adr_i = adr;
      cpu_dat_i = dat;
      cpu_sel_i = sel;
      cpu_we_i  = we;
      cpu_cyc_i = 1'b1;
      cpu_stb_i = 1'b1;
    end
    while (!done && waited < TIMEOUT) begin
      @(negedge wb_clk_i);
      waited++;
      done = use_dbg ? (dbg_ack_o | dbg_err_o) : (cpu_ack_o | cpu_err_o);
    end
    if (!done) begin
      stop_on_failure($sformatf("Timeout: the %s master got no ack or err within %0d cycles",
                                use_dbg ? "debug" : "CPU", TIMEOUT));
    end else begin
      // Response is sampled on the next rising edge, release after it
      @(negedge wb_clk_i);
      if (use_dbg) begin
        dbg_cyc_i = 1'b0;
        dbg_stb_i = 1'b0;
        dbg_we_i  = 1'b0;
      end else begin
        cpu_cyc_i = 1'b0;
        cpu_stb_i = 1'b0;
        cpu_we_i  = 1'b0;
      end
    end
  endtask

  task automatic read_all();
    for (int w = 0; w < 1024; w++) begin
      transfer(w[0], mapped_addr(w), '0, 4'hf, 1'b0);
    end
  endtask

  // Mostly mapped, one in eight unmapped
  task automatic random_traffic(input bit use_dbg, input int count);
    wb_soc_pkg::wb_addr_t adr;
    for (int n = 0; n < count; n++) begin
      if ($urandom_range(7, 0) == 0) begin
        adr = unmapped_addr();
      end else begin
        adr = mapped_addr($urandom_range(1023, 0));
      end
      transfer(use_dbg, adr, $urandom(), wb_soc_pkg::wb_sel_t'($urandom_range(15, 1)),
               1'($urandom_range(1, 0)));
      repeat ($urandom_range(2, 0)) @(negedge wb_clk_i);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  assign cpu_exp = ref_mem[cpu_adr_i[11:2]];
  assign dbg_exp = ref_mem[dbg_adr_i[11:2]];

  // Writes land in grant order, one ack per edge
  always_ff @(posedge wb_clk_i) begin
    if (!reset_i && cpu_ack_o && cpu_we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (cpu_sel_i[b]) ref_mem[cpu_adr_i[11:2]][8*b +: 8] <= cpu_dat_i[8*b +: 8];
      end
    end
    if (!reset_i && dbg_ack_o && dbg_we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (dbg_sel_i[b]) ref_mem[dbg_adr_i[11:2]][8*b +: 8] <= dbg_dat_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      // CPU wins the first tie
      last_dbg <= 1'b1;
      tie_done <= 1'b0;
    end else begin
      if (cpu_ack_o || cpu_err_o) last_dbg <= 1'b0;
      if (dbg_ack_o || dbg_err_o) last_dbg <= 1'b1;
      if (!tie_open) begin
        tie_done <= 1'b0;
      end else if (cpu_ack_o || cpu_err_o || dbg_ack_o || dbg_err_o) begin
        tie_done <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  assert property (@(posedge wb_clk_i) disable iff (reset_i)
    !cpu_stb_i |-> !cpu_ack_o && !cpu_err_o)
    else stop_on_failure($sformatf("ERR %0t: CPU response while its stb is low", $time));
  assert property (@(posedge wb_clk_i) disable iff (reset_i)
    !dbg_stb_i |-> !dbg_ack_o && !dbg_err_o)
    else stop_on_failure($sformatf("ERR %0t: debug response while its stb is low", $time));
  assert property (@(posedge wb_clk_i) disable iff (reset_i)
    !(cpu_ack_o && cpu_err_o) && !(dbg_ack_o && dbg_err_o))
    else stop_on_failure($sformatf("ERR %0t: ack and err high together", $time));
  // Single pulse per cycle
  assert property (@(posedge wb_clk_i) disable iff (reset_i)
    (cpu_ack_o || cpu_err_o) |=> !(cpu_ack_o || cpu_err_o))
    else stop_on_failure($sformatf("ERR %0t: CPU response longer than one cycle", $time));
  assert property (@(posedge wb_clk_i) disable iff (reset_i)
    (dbg_ack_o || dbg_err_o) |=> !(dbg_ack_o || dbg_err_o))
    else stop_on_failure($sformatf("ERR %0t: debug response longer than one cycle", $time));

  // Err for unmapped, ack for mapped
  assert property (@(posedge wb_clk_i) disable iff (reset_i)
    (cpu_ack_o || cpu_err_o) |-> (cpu_err_o == (|cpu_adr_i[31:12])))
    else stop_on_failure($sformatf("ERR %0t: CPU ack/err wrong for %h", $time,
                                   $sampled(cpu_adr_i)));
  assert property (@(posedge wb_clk_i) disable iff (reset_i)
    (dbg_ack_o || dbg_err_o) |-> (dbg_err_o == (|dbg_adr_i[31:12])))
    else stop_on_failure($sformatf("ERR %0t: debug ack/err wrong for %h", $time,
                                   $sampled(dbg_adr_i)));

  assert property (@(posedge wb_clk_i) disable iff (reset_i)
    (cpu_ack_o && !cpu_we_i) |-> (cpu_dat_o == cpu_exp))
    else stop_on_failure($sformatf("ERR %0t: CPU read %h, expected %h", $time,
                                   $sampled(cpu_dat_o), $sampled(cpu_exp)));
  assert property (@(posedge wb_clk_i) disable iff (reset_i)
    (dbg_ack_o && !dbg_we_i) |-> (dbg_dat_o == dbg_exp))
    else stop_on_failure($sformatf("ERR %0t: debug read %h, expected %h", $time,
                                   $sampled(dbg_dat_o), $sampled(dbg_exp)));

  // First completion of a tie goes to the master not granted last
  assert property (@(posedge wb_clk_i) disable iff (reset_i)
    (tie_open && !tie_done && (cpu_ack_o || cpu_err_o || dbg_ack_o || dbg_err_o))
    |-> ((dbg_ack_o || dbg_err_o) == !last_dbg))
    else stop_on_failure($sformatf("ERR %0t: tie won by the master granted last", $time));

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    int w;
    reset_i   = 1'b1;
    tie_open  = 1'b0;
    cpu_adr_i = '0;
    cpu_dat_i = '0;
    cpu_sel_i = '0;
    cpu_we_i  = 1'b0;
    cpu_cyc_i = 1'b0;
    cpu_stb_i = 1'b0;
    dbg_adr_i = '0;
    dbg_dat_i = '0;
    dbg_sel_i = '0;
    dbg_we_i  = 1'b0;
    dbg_cyc_i = 1'b0;
    dbg_stb_i = 1'b0;
    void'($urandom(SEED));
    repeat (16) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    reset_i = 1'b0;

    // Defined contents everywhere, banks are not reset
    for (w = 0; w < 1024; w++) begin
      transfer(w[0], mapped_addr(w), $urandom(), 4'hf, 1'b1);
    end

    // Write then read back per bank, partial selects
    for (int b = 0; b < wb_soc_pkg::NUM_BANKS; b++) begin
      for (int r = 0; r < 8; r++) begin
        w = b * 256 + $urandom_range(255, 0);
        transfer(r[0], mapped_addr(w), $urandom(),
                 wb_soc_pkg::wb_sel_t'($urandom_range(15, 1)), 1'b1);
        transfer(r[0], mapped_addr(w), '0, 4'hf, 1'b0);
      end
    end

    // Unmapped cycles, then the window must be unchanged
    for (int u = 0; u < 32; u++) begin
      transfer(u[0], unmapped_addr(), $urandom(), 4'hf, u[1]);
    end
    read_all();

    // Both masters at once
    fork
      random_traffic(1'b0, NUM_RANDOM);
      random_traffic(1'b1, NUM_RANDOM);
    join

    for (int t = 0; t < NUM_TIES; t++) begin
      // Vary who went last
      transfer(1'($urandom_range(1, 0)), mapped_addr($urandom_range(1023, 0)), $urandom(),
               4'hf, 1'b1);
      repeat (2) @(negedge wb_clk_i);
      tie_open = 1'b1;
      fork
        transfer(1'b0, mapped_addr($urandom_range(1023, 0)), $urandom(), 4'hf, 1'b1);
        transfer(1'b1, mapped_addr($urandom_range(1023, 0)), '0, 4'hf, 1'b0);
      join
      tie_open = 1'b0;
      repeat (2) @(negedge wb_clk_i);
    end

    read_all();
    $display("Simulation passed");
    $finish;
  end

endmodule
